/* verilog/ctrl_pkg.sv */
package ctrl_pkg;

  //////////////////////////////////////////////////
  // Controller state
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    RESET,
    BOOT_SET,
    FUNCTIONAL,
    SLEEP
  } ctrl_state_e;

  // Next PC source for the IF stage
  typedef logic [2:0] pc_mux_t;
  localparam pc_mux_t PC_BOOT      = 3'd0;
  localparam pc_mux_t PC_JUMP      = 3'd1;
  localparam pc_mux_t PC_BRANCH    = 3'd2;
  localparam pc_mux_t PC_EXCEPTION = 3'd3;

  // Handler base select
  typedef logic [1:0] exc_pc_mux_t;
  localparam exc_pc_mux_t EXC_PC_EXCEPTION = 2'd0;
  localparam exc_pc_mux_t EXC_PC_IRQ       = 2'd1;

  // Exception and interrupt codes
  typedef logic [4:0] exc_cause_t;
  localparam exc_cause_t EXC_CAUSE_INSTR_FAULT  = 5'd1;
  localparam exc_cause_t EXC_CAUSE_ILLEGAL_INSN = 5'd2;
  localparam exc_cause_t EXC_CAUSE_BREAKPOINT   = 5'd3;
  localparam exc_cause_t EXC_CAUSE_LOAD_FAULT   = 5'd5;
  localparam exc_cause_t EXC_CAUSE_STORE_FAULT  = 5'd7;
  localparam exc_cause_t EXC_CAUSE_ECALL_MMODE  = 5'd11;

  // Cause as written to the CSRs, top bit set for interrupts
  typedef logic [5:0] csr_cause_t;

  // Stage whose PC gets saved
  typedef logic [1:0] save_sel_t;
  localparam save_sel_t SAVE_IF = 2'd0;
  localparam save_sel_t SAVE_ID = 2'd1;
  localparam save_sel_t SAVE_EX = 2'd2;
  localparam save_sel_t SAVE_WB = 2'd3;

  // Handler vector mode, anything but direct is vectored
  typedef logic [1:0] vec_mode_t;
  localparam vec_mode_t VEC_MODE_DIRECT = 2'd0;

  // Configuration write port selects
  localparam logic CFG_SEL_VEC_MODE = 1'b0;
  localparam logic CFG_SEL_IRQ_EN   = 1'b1;

endpackage

/* verilog/ctrl_cfg_regs.sv */
`timescale 1ns/1ps

module ctrl_cfg_regs (
  input  logic              clk,
  input  logic              rst_n,
  // Write port
  input  logic              cfg_we_i,
  input  logic              cfg_sel_i,
  input  ctrl_pkg::vec_mode_t cfg_wdata_i,
  // To the controller
  output logic              irq_en_o,
  output ctrl_pkg::vec_mode_t vec_mode_o
);

  logic                irq_en_q;
  ctrl_pkg::vec_mode_t vec_mode_q;

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////

  // Global interrupt enable and handler vector mode
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      irq_en_q   <= 1'b0;
      vec_mode_q <= ctrl_pkg::VEC_MODE_DIRECT;
    end else if (cfg_we_i) begin
      if (cfg_sel_i == ctrl_pkg::CFG_SEL_IRQ_EN) begin
        irq_en_q <= cfg_wdata_i[0];
      end else begin
        vec_mode_q <= cfg_wdata_i;
      end
    end
  end

  assign irq_en_o   = irq_en_q;
  assign vec_mode_o = vec_mode_q;

  // Enable write carries only bit 0
  a_irq_en_write : assert property (
    @(posedge clk) disable iff (!rst_n)
    cfg_we_i && (cfg_sel_i == ctrl_pkg::CFG_SEL_IRQ_EN) |-> (cfg_wdata_i[1] == 1'b0)
  );

endmodule

/* verilog/ctrl_event_decode.sv */
`timescale 1ns/1ps

module ctrl_event_decode (
  input  logic                 clk,
  input  logic                 rst_n,
  // ID stage
  input  logic                 id_valid_i,
  input  logic                 id_jump_i,
  input  logic                 jr_stall_i,
  // EX stage
  input  logic                 ex_valid_i,
  input  logic                 ex_branch_i,
  input  logic                 ex_lsu_misaligned_i,
  input  logic                 data_req_i,
  input  logic                 ex_advance_i,
  // IF stage
  input  logic                 if_fire_i,
  // WB stage
  input  logic                 wb_valid_i,
  input  logic                 wb_instr_fault_i,
  input  logic                 wb_illegal_i,
  input  logic                 wb_ecall_i,
  input  logic                 wb_ebreak_i,
  input  logic                 wb_load_fault_i,
  input  logic                 wb_store_fault_i,
  input  logic                 wb_lsu_en_i,
  input  logic                 wb_wfi_i,
  // Interrupts
  input  logic                 irq_req_i,
  input  logic                 irq_en_i,
  // From the FSM
  input  logic                 taken_set_i,
  // Event flags
  output logic                 exception_in_wb_o,
  output ctrl_pkg::exc_cause_t exc_cause_wb_o,
  output logic                 wfi_in_wb_o,
  output logic                 branch_taken_ex_o,
  output logic                 jump_taken_id_o,
  output logic                 irq_pending_o,
  output logic                 irq_allowed_o
);

  // Redirect already issued for the instruction in ID/EX
  logic taken_q;
  // Data request went out but the LSU insn is still in EX
  logic data_req_q;

  //////////////////////////////////////////////////
  // WB events
  //////////////////////////////////////////////////

  assign exception_in_wb_o = wb_valid_i && (wb_instr_fault_i || wb_illegal_i || wb_ecall_i ||
                                            wb_ebreak_i || wb_store_fault_i || wb_load_fault_i);

  // Fixed cause priority
  assign exc_cause_wb_o = wb_instr_fault_i ? ctrl_pkg::EXC_CAUSE_INSTR_FAULT  :
                          wb_illegal_i     ? ctrl_pkg::EXC_CAUSE_ILLEGAL_INSN :
                          wb_ecall_i       ? ctrl_pkg::EXC_CAUSE_ECALL_MMODE  :
                          wb_ebreak_i      ? ctrl_pkg::EXC_CAUSE_BREAKPOINT   :
                          wb_store_fault_i ? ctrl_pkg::EXC_CAUSE_STORE_FAULT  :
                          wb_load_fault_i  ? ctrl_pkg::EXC_CAUSE_LOAD_FAULT   :
                          '0;

  assign wfi_in_wb_o = wb_valid_i && wb_wfi_i;

  //////////////////////////////////////////////////
  // Jumps and branches
  //////////////////////////////////////////////////

  // Jump waits for its register operand
  assign jump_taken_id_o   = id_valid_i && id_jump_i && !jr_stall_i && !taken_q;
  assign branch_taken_ex_o = ex_valid_i && ex_branch_i && !taken_q;

  // Cleared once IF hands over the next instruction
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      taken_q <= 1'b0;
    end else if (taken_set_i) begin
      taken_q <= 1'b1;
    end else if (if_fire_i) begin
      taken_q <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Interrupt permission
  //////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      data_req_q <= 1'b0;
    end else if (ex_advance_i) begin
      data_req_q <= 1'b0;
    end else if (data_req_i) begin
      data_req_q <= 1'b1;
    end
  end

  assign irq_pending_o = irq_req_i && irq_en_i;

  // LSU insn in WB or a data request already out waits for its response
  assign irq_allowed_o = !(wb_valid_i && wb_lsu_en_i) && !data_req_q &&
                         !(ex_valid_i && ex_lsu_misaligned_i);

  // No redirect in the same cycle as a fetch handover
  a_taken_set_no_fire : assert property (
    @(posedge clk) disable iff (!rst_n)
    taken_set_i |-> !if_fire_i
  );

endmodule

/* verilog/ctrl_fsm.sv */
`timescale 1ns/1ps

module ctrl_fsm (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  fetch_enable_i,
  // Event flags
  input  logic                  exception_in_wb_i,
  input  ctrl_pkg::exc_cause_t  exc_cause_wb_i,
  input  logic                  wfi_in_wb_i,
  input  logic                  branch_taken_ex_i,
  input  logic                  jump_taken_id_i,
  input  logic                  irq_pending_i,
  input  logic                  irq_allowed_i,
  // Hazards and stage valids
  input  logic                  load_stall_i,
  input  logic                  jr_stall_i,
  input  logic                  ex_stall_i,
  input  logic                  id_valid_i,
  input  logic                  ex_valid_i,
  input  logic                  wb_valid_i,
  // Interrupt controller and config
  input  ctrl_pkg::exc_cause_t  irq_id_i,
  input  logic                  irq_wu_i,
  input  ctrl_pkg::vec_mode_t   vec_mode_i,
  // Outputs
  output logic                  instr_req_o,
  output logic                  ctrl_busy_o,
  output logic                  pc_set_o,
  output ctrl_pkg::pc_mux_t     pc_mux_o,
  output ctrl_pkg::exc_pc_mux_t exc_pc_mux_o,
  output ctrl_pkg::exc_cause_t  exc_vec_sel_o,
  output logic                  kill_if_o,
  output logic                  kill_id_o,
  output logic                  kill_ex_o,
  output logic                  kill_wb_o,
  output logic                  halt_if_o,
  output logic                  halt_id_o,
  output logic                  halt_ex_o,
  output logic                  halt_wb_o,
  output logic                  irq_ack_o,
  output ctrl_pkg::exc_cause_t  irq_id_o,
  output logic                  csr_save_cause_o,
  output ctrl_pkg::csr_cause_t  csr_cause_o,
  output ctrl_pkg::save_sel_t   csr_save_sel_o,
  output logic                  taken_set_o
);

  ctrl_pkg::ctrl_state_e state_q, state_d;
  // Id of a taken interrupt, zero otherwise
  ctrl_pkg::exc_cause_t  exc_cause;

  // Vector offset only in vectored mode
  assign exc_vec_sel_o = (vec_mode_i == ctrl_pkg::VEC_MODE_DIRECT) ? '0 : exc_cause;

  //////////////////////////////////////////////////
  // Next state and outputs
  //////////////////////////////////////////////////

  always_comb begin
    state_d          = state_q;
    instr_req_o      = 1'b1;
    ctrl_busy_o      = 1'b1;
    pc_set_o         = 1'b0;
    pc_mux_o         = ctrl_pkg::PC_BOOT;
    exc_pc_mux_o     = ctrl_pkg::EXC_PC_IRQ;
    exc_cause        = '0;
    {kill_if_o, kill_id_o, kill_ex_o, kill_wb_o} = 4'b0000;
    halt_if_o        = 1'b0;
    // Unallowed interrupt leaves an interruptible bubble behind ID
    halt_id_o        = jr_stall_i || load_stall_i || (irq_pending_i && !irq_allowed_i);
    halt_ex_o        = ex_stall_i;
    halt_wb_o        = 1'b0;
    irq_ack_o        = 1'b0;
    irq_id_o         = '0;
    csr_save_cause_o = 1'b0;
    csr_cause_o      = '0;
    csr_save_sel_o   = ctrl_pkg::SAVE_IF;
    taken_set_o      = 1'b0;

    unique case (state_q)
      ctrl_pkg::RESET: begin
        instr_req_o = 1'b0;
        halt_id_o   = 1'b0;
        halt_ex_o   = 1'b0;
        if (fetch_enable_i) begin
          state_d = ctrl_pkg::BOOT_SET;
        end
      end
      // Boot PC set once, one cycle after enable
      ctrl_pkg::BOOT_SET: begin
        pc_set_o = 1'b1;
        pc_mux_o = ctrl_pkg::PC_BOOT;
        state_d  = ctrl_pkg::FUNCTIONAL;
      end
      ctrl_pkg::FUNCTIONAL: begin
        if (irq_pending_i && irq_allowed_i) begin
          // Flush everything and go to the handler
          {kill_if_o, kill_id_o, kill_ex_o, kill_wb_o} = 4'b1111;
          pc_set_o         = 1'b1;
          pc_mux_o         = ctrl_pkg::PC_EXCEPTION;
          exc_pc_mux_o     = ctrl_pkg::EXC_PC_IRQ;
          exc_cause        = irq_id_i;
          irq_ack_o        = 1'b1;
          irq_id_o         = irq_id_i;
          csr_save_cause_o = 1'b1;
          csr_cause_o      = {1'b1, irq_id_i};
          // PC of the oldest valid insn, IF PC is always valid
          if (wb_valid_i) begin
            csr_save_sel_o = ctrl_pkg::SAVE_WB;
          end else if (ex_valid_i) begin
            csr_save_sel_o = ctrl_pkg::SAVE_EX;
          end else if (id_valid_i) begin
            csr_save_sel_o = ctrl_pkg::SAVE_ID;
          end else begin
            csr_save_sel_o = ctrl_pkg::SAVE_IF;
          end
        end else if (exception_in_wb_i) begin
          // WB write enables are suppressed already
          {kill_if_o, kill_id_o, kill_ex_o} = 3'b111;
          pc_set_o         = 1'b1;
          pc_mux_o         = ctrl_pkg::PC_EXCEPTION;
          exc_pc_mux_o     = ctrl_pkg::EXC_PC_EXCEPTION;
          csr_save_cause_o = 1'b1;
          csr_cause_o      = {1'b0, exc_cause_wb_i};
          csr_save_sel_o   = ctrl_pkg::SAVE_WB;
        end else if (wfi_in_wb_i) begin
          // EX and WB keep going so the bubble drains
          halt_if_o   = 1'b1;
          halt_id_o   = 1'b1;
          instr_req_o = 1'b0;
          state_d     = ctrl_pkg::SLEEP;
        end else if (branch_taken_ex_i) begin
          kill_if_o   = 1'b1;
          kill_id_o   = 1'b1;
          pc_set_o    = 1'b1;
          pc_mux_o    = ctrl_pkg::PC_BRANCH;
          taken_set_o = 1'b1;
        end else if (jump_taken_id_i) begin
          kill_if_o   = 1'b1;
          pc_set_o    = 1'b1;
          pc_mux_o    = ctrl_pkg::PC_JUMP;
          taken_set_o = 1'b1;
        end
      end
      ctrl_pkg::SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        // Halting WB stalls the earlier stages too
        halt_wb_o   = 1'b1;
        if (irq_wu_i) begin
          ctrl_busy_o = 1'b1;
          state_d     = ctrl_pkg::FUNCTIONAL;
        end
      end
      default: begin
        instr_req_o = 1'b0;
        state_d     = ctrl_pkg::RESET;
      end
    endcase
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ctrl_pkg::RESET;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Outside FUNCTIONAL only the boot set follows RESET
  a_pc_set_state : assert property (
    @(posedge clk) disable iff (!rst_n)
    (pc_set_o || irq_ack_o) && (state_q != ctrl_pkg::FUNCTIONAL)
    |-> (state_q == ctrl_pkg::BOOT_SET) && !irq_ack_o && ($past(state_q) == ctrl_pkg::RESET)
  );

  // Fetch already stopped in the cycle before sleep
  a_sleep_no_req : assert property (
    @(posedge clk) disable iff (!rst_n)
    (state_q == ctrl_pkg::SLEEP) |-> !instr_req_o && !$past(instr_req_o)
  );

endmodule

/* verilog/pipe_ctrl_top.sv */
`timescale 1ns/1ps

module pipe_ctrl_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  fetch_enable_i,
  // Configuration write port
  input  logic                  cfg_we_i,
  input  logic                  cfg_sel_i,
  input  ctrl_pkg::vec_mode_t   cfg_wdata_i,
  // IF and ID
  input  logic                  if_fire_i,
  input  logic                  id_valid_i,
  input  logic                  id_jump_i,
  input  logic                  jr_stall_i,
  input  logic                  load_stall_i,
  // EX
  input  logic                  ex_valid_i,
  input  logic                  ex_branch_i,
  input  logic                  ex_lsu_misaligned_i,
  input  logic                  ex_stall_i,
  input  logic                  ex_advance_i,
  input  logic                  data_req_i,
  // WB
  input  logic                  wb_valid_i,
  input  logic                  wb_instr_fault_i,
  input  logic                  wb_illegal_i,
  input  logic                  wb_ecall_i,
  input  logic                  wb_ebreak_i,
  input  logic                  wb_load_fault_i,
  input  logic                  wb_store_fault_i,
  input  logic                  wb_lsu_en_i,
  input  logic                  wb_wfi_i,
  // Interrupt controller
  input  logic                  irq_req_i,
  input  ctrl_pkg::exc_cause_t  irq_id_i,
  input  logic                  irq_wu_i,
  // Controller outputs
  output logic                  instr_req_o,
  output logic                  ctrl_busy_o,
  output logic                  pc_set_o,
  output ctrl_pkg::pc_mux_t     pc_mux_o,
  output ctrl_pkg::exc_pc_mux_t exc_pc_mux_o,
  output ctrl_pkg::exc_cause_t  exc_vec_sel_o,
  output logic                  kill_if_o,
  output logic                  kill_id_o,
  output logic                  kill_ex_o,
  output logic                  kill_wb_o,
  output logic                  halt_if_o,
  output logic                  halt_id_o,
  output logic                  halt_ex_o,
  output logic                  halt_wb_o,
  output logic                  irq_ack_o,
  output ctrl_pkg::exc_cause_t  irq_id_o,
  output logic                  csr_save_cause_o,
  output ctrl_pkg::csr_cause_t  csr_cause_o,
  output ctrl_pkg::save_sel_t   csr_save_sel_o
);

  // Config to controller
  logic                 irq_en;
  ctrl_pkg::vec_mode_t  vec_mode;
  // Decoder events
  logic                 exception_in_wb;
  ctrl_pkg::exc_cause_t exc_cause_wb;
  logic                 wfi_in_wb;
  logic                 branch_taken_ex;
  logic                 jump_taken_id;
  logic                 irq_pending;
  logic                 irq_allowed;
  logic                 taken_set;

  ctrl_cfg_regs ctrl_cfg_regs_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg_we_i    (cfg_we_i),
    .cfg_sel_i   (cfg_sel_i),
    .cfg_wdata_i (cfg_wdata_i),
    .irq_en_o    (irq_en),
    .vec_mode_o  (vec_mode)
  );

  ctrl_event_decode ctrl_event_decode_inst (
    .clk                 (clk),
    .rst_n               (rst_n),
    .id_valid_i          (id_valid_i),
    .id_jump_i           (id_jump_i),
    .jr_stall_i          (jr_stall_i),
    .ex_valid_i          (ex_valid_i),
    .ex_branch_i         (ex_branch_i),
    .ex_lsu_misaligned_i (ex_lsu_misaligned_i),
    .data_req_i          (data_req_i),
    .ex_advance_i        (ex_advance_i),
    .if_fire_i           (if_fire_i),
    .wb_valid_i          (wb_valid_i),
    .wb_instr_fault_i    (wb_instr_fault_i),
    .wb_illegal_i        (wb_illegal_i),
    .wb_ecall_i          (wb_ecall_i),
    .wb_ebreak_i         (wb_ebreak_i),
    .wb_load_fault_i     (wb_load_fault_i),
    .wb_store_fault_i    (wb_store_fault_i),
    .wb_lsu_en_i         (wb_lsu_en_i),
    .wb_wfi_i            (wb_wfi_i),
    .irq_req_i           (irq_req_i),
    .irq_en_i            (irq_en),
    .taken_set_i         (taken_set),
    .exception_in_wb_o   (exception_in_wb),
    .exc_cause_wb_o      (exc_cause_wb),
    .wfi_in_wb_o         (wfi_in_wb),
    .branch_taken_ex_o   (branch_taken_ex),
    .jump_taken_id_o     (jump_taken_id),
    .irq_pending_o       (irq_pending),
    .irq_allowed_o       (irq_allowed)
  );

  ctrl_fsm ctrl_fsm_inst (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable_i),
    .exception_in_wb_i (exception_in_wb),
    .exc_cause_wb_i    (exc_cause_wb),
    .wfi_in_wb_i       (wfi_in_wb),
    .branch_taken_ex_i (branch_taken_ex),
    .jump_taken_id_i   (jump_taken_id),
    .irq_pending_i     (irq_pending),
    .irq_allowed_i     (irq_allowed),
    .load_stall_i      (load_stall_i),
    .jr_stall_i        (jr_stall_i),
    .ex_stall_i        (ex_stall_i),
    .id_valid_i        (id_valid_i),
    .ex_valid_i        (ex_valid_i),
    .wb_valid_i        (wb_valid_i),
    .irq_id_i          (irq_id_i),
    .irq_wu_i          (irq_wu_i),
    .vec_mode_i        (vec_mode),
    .instr_req_o       (instr_req_o),
    .ctrl_busy_o       (ctrl_busy_o),
    .pc_set_o          (pc_set_o),
    .pc_mux_o          (pc_mux_o),
    .exc_pc_mux_o      (exc_pc_mux_o),
    .exc_vec_sel_o     (exc_vec_sel_o),
    .kill_if_o         (kill_if_o),
    .kill_id_o         (kill_id_o),
    .kill_ex_o         (kill_ex_o),
    .kill_wb_o         (kill_wb_o),
    .halt_if_o         (halt_if_o),
    .halt_id_o         (halt_id_o),
    .halt_ex_o         (halt_ex_o),
    .halt_wb_o         (halt_wb_o),
    .irq_ack_o         (irq_ack_o),
    .irq_id_o          (irq_id_o),
    .csr_save_cause_o  (csr_save_cause_o),
    .csr_cause_o       (csr_cause_o),
    .csr_save_sel_o    (csr_save_sel_o),
    .taken_set_o       (taken_set)
  );

endmodule

/* test/tb_pipe_ctrl_table.svh */
`ifndef TB_PIPE_CTRL_TABLE_SVH
`define TB_PIPE_CTRL_TABLE_SVH

// Stimulus line: cfg {we,sel,wdata}, fetch_en, ifid {fire,id_valid,jump,jr_stall,load_stall},
// ex {valid,branch,misaligned,stall,advance,data_req},
// wb {valid,instr_f,illegal,ecall,ebreak,load_f,store_f,lsu_en,wfi},
// irq {req,wu}, random mask {id_jump,ex_branch}, hold cycles
// Expected line: {instr_req,busy}, pc_set, pc_mux, kill {if,id,ex,wb}, halt {if,id,ex,wb},
// {irq_ack,save_cause}, exception cause, save select (0 IF, 1 ID, 2 EX, 3 WB)
// pc_mux codes: 0 boot, 1 jump, 2 branch, 3 exception

localparam int NUM_ROWS = 25;

function automatic row_t table_row(input int idx);
  row_t r;
  r = '0;
  case (idx)
    // Boot sequence
    0: r = '{4'b0000, 1'b0, 5'b00000, 6'b000000, 9'b000000000, 2'b00, 2'b00, 8'd2,
             2'b01, 1'b0, 3'd0, 4'b0000, 4'b0000, 2'b00, 5'd0, 2'd0};
    1: r = '{4'b0000, 1'b1, 5'b00000, 6'b000000, 9'b000000000, 2'b00, 2'b00, 8'd1,
             2'b01, 1'b0, 3'd0, 4'b0000, 4'b0000, 2'b00, 5'd0, 2'd0};
    2: r = '{4'b0000, 1'b1, 5'b00000, 6'b000000, 9'b000000000, 2'b00, 2'b00, 8'd1,
             2'b11, 1'b1, 3'd0, 4'b0000, 4'b0000, 2'b00, 5'd0, 2'd0};
    // Idle while the interrupt enable gets written
    3: r = '{4'b1101, 1'b1, 5'b00000, 6'b000000, 9'b000000000, 2'b00, 2'b00, 8'd3,
             2'b11, 1'b0, 3'd0, 4'b0000, 4'b0000, 2'b00, 5'd0, 2'd0};
    // WB exceptions, several fault flags at once
    4: r = '{4'b0000, 1'b1, 5'b01000, 6'b100000, 9'b101011000, 2'b00, 2'b11, 8'd1,
             2'b11, 1'b1, 3'd3, 4'b1110, 4'b0000, 2'b01, 5'd2, 2'd3};
    5: r = '{4'b0000, 1'b1, 5'b01000, 6'b100000, 9'b100111100, 2'b00, 2'b11, 8'd1,
             2'b11, 1'b1, 3'd3, 4'b1110, 4'b0000, 2'b01, 5'd11, 2'd3};
    6: r = '{4'b0000, 1'b1, 5'b01000, 6'b100000, 9'b100011100, 2'b00, 2'b11, 8'd1,
             2'b11, 1'b1, 3'd3, 4'b1110, 4'b0000, 2'b01, 5'd3, 2'd3};
    7: r = '{4'b0000, 1'b1, 5'b01000, 6'b100000, 9'b100001100, 2'b00, 2'b11, 8'd1,
             2'b11, 1'b1, 3'd3, 4'b1110, 4'b0000, 2'b01, 5'd7, 2'd3};
    8: r = '{4'b0000, 1'b1, 5'b01000, 6'b100000, 9'b111111100, 2'b00, 2'b11, 8'd1,
             2'b11, 1'b1, 3'd3, 4'b1110, 4'b0000, 2'b01, 5'd1, 2'd3};
    // Interrupt in direct mode, oldest valid stage is EX
    9: r = '{4'b0000, 1'b1, 5'b01000, 6'b100000, 9'b000000000, 2'b10, 2'b11, 8'd1,
             2'b11, 1'b1, 3'd3, 4'b1111, 4'b0000, 2'b11, 5'd0, 2'd2};
    // Switch to vectored mode
    10: r = '{4'b1001, 1'b1, 5'b00000, 6'b000000, 9'b000000000, 2'b00, 2'b00, 8'd1,
              2'b11, 1'b0, 3'd0, 4'b0000, 4'b0000, 2'b00, 5'd0, 2'd0};
    11: r = '{4'b0000, 1'b1, 5'b00000, 6'b000000, 9'b100000000, 2'b10, 2'b00, 8'd1,
              2'b11, 1'b1, 3'd3, 4'b1111, 4'b0000, 2'b11, 5'd0, 2'd3};
    // Load/store in WB blocks the interrupt and halts ID
    12: r = '{4'b0000, 1'b1, 5'b00000, 6'b000000, 9'b100000010, 2'b10, 2'b00, 8'd2,
              2'b11, 1'b0, 3'd0, 4'b0000, 4'b0100, 2'b00, 5'd0, 2'd0};
    13: r = '{4'b0000, 1'b1, 5'b01000, 6'b000000, 9'b000000000, 2'b10, 2'b00, 8'd1,
              2'b11, 1'b1, 3'd3, 4'b1111, 4'b0000, 2'b11, 5'd0, 2'd1};
    // Enable cleared, request ignored
    14: r = '{4'b1100, 1'b1, 5'b00000, 6'b000000, 9'b000000000, 2'b00, 2'b00, 8'd1,
              2'b11, 1'b0, 3'd0, 4'b0000, 4'b0000, 2'b00, 5'd0, 2'd0};
    15: r = '{4'b0000, 1'b1, 5'b00000, 6'b100000, 9'b000000000, 2'b10, 2'b00, 8'd2,
              2'b11, 1'b0, 3'd0, 4'b0000, 4'b0000, 2'b00, 5'd0, 2'd0};
    // Branch taken once, then held by an EX stall
    16: r = '{4'b0000, 1'b1, 5'b00000, 6'b110000, 9'b000000000, 2'b00, 2'b00, 8'd1,
              2'b11, 1'b1, 3'd2, 4'b1100, 4'b0000, 2'b00, 5'd0, 2'd0};
    17: r = '{4'b0000, 1'b1, 5'b00000, 6'b110100, 9'b000000000, 2'b00, 2'b00, 8'd3,
              2'b11, 1'b0, 3'd0, 4'b0000, 4'b0010, 2'b00, 5'd0, 2'd0};
    18: r = '{4'b0000, 1'b1, 5'b10000, 6'b000000, 9'b000000000, 2'b00, 2'b00, 8'd1,
              2'b11, 1'b0, 3'd0, 4'b0000, 4'b0000, 2'b00, 5'd0, 2'd0};
    // New jump after the fetch, taken once
    19: r = '{4'b0000, 1'b1, 5'b01100, 6'b000000, 9'b000000000, 2'b00, 2'b00, 8'd1,
              2'b11, 1'b1, 3'd1, 4'b1000, 4'b0000, 2'b00, 5'd0, 2'd0};
    20: r = '{4'b0000, 1'b1, 5'b01100, 6'b000000, 9'b000000000, 2'b00, 2'b00, 8'd2,
              2'b11, 1'b0, 3'd0, 4'b0000, 4'b0000, 2'b00, 5'd0, 2'd0};
    // WFI, sleep and wake-up
    21: r = '{4'b0000, 1'b1, 5'b00000, 6'b000000, 9'b100000001, 2'b00, 2'b00, 8'd1,
              2'b01, 1'b0, 3'd0, 4'b0000, 4'b1100, 2'b00, 5'd0, 2'd0};
    22: r = '{4'b0000, 1'b1, 5'b00000, 6'b000000, 9'b000000000, 2'b00, 2'b00, 8'd2,
              2'b00, 1'b0, 3'd0, 4'b0000, 4'b0001, 2'b00, 5'd0, 2'd0};
    23: r = '{4'b0000, 1'b1, 5'b00000, 6'b000000, 9'b000000000, 2'b01, 2'b00, 8'd1,
              2'b01, 1'b0, 3'd0, 4'b0000, 4'b0001, 2'b00, 5'd0, 2'd0};
    24: r = '{4'b0000, 1'b1, 5'b00000, 6'b000000, 9'b000000000, 2'b00, 2'b00, 8'd2,
              2'b11, 1'b0, 3'd0, 4'b0000, 4'b0000, 2'b00, 5'd0, 2'd0};
    default: r = '0;
  endcase
  return r;
endfunction

`endif

/* test/tb_pipe_ctrl.sv */
`timescale 1ns/1ps

module tb_pipe_ctrl;

  localparam int HALF_PERIOD = 10;

  // One table row, stimulus first and expected outputs after
  typedef struct packed {
    logic [3:0]          cfg;
    logic                fe;
    logic [4:0]          ifid;
    logic [5:0]          ex;
    logic [8:0]          wb;
    logic [1:0]          irq;
    logic [1:0]          dc;
    logic [7:0]          hold;
    logic [1:0]          e_rb;
    logic                e_set;
    ctrl_pkg::pc_mux_t   e_mux;
    logic [3:0]          e_kill;
    logic [3:0]          e_halt;
    logic [1:0]          e_as;
    ctrl_pkg::exc_cause_t e_exc;
    ctrl_pkg::save_sel_t e_sel;
  } row_t;

  `include "tb_pipe_ctrl_table.svh"

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  fetch_enable_i;
  logic                  cfg_we_i;
  logic                  cfg_sel_i;
  ctrl_pkg::vec_mode_t   cfg_wdata_i;
  logic                  if_fire_i, id_valid_i, id_jump_i, jr_stall_i, load_stall_i;
  logic                  ex_valid_i, ex_branch_i, ex_lsu_misaligned_i;
  logic                  ex_stall_i, ex_advance_i, data_req_i;
  logic                  wb_valid_i, wb_instr_fault_i, wb_illegal_i, wb_ecall_i;
  logic                  wb_ebreak_i, wb_load_fault_i, wb_store_fault_i;
  logic                  wb_lsu_en_i, wb_wfi_i;
  logic                  irq_req_i, irq_wu_i;
  ctrl_pkg::exc_cause_t  irq_id_i;
  logic                  instr_req_o, ctrl_busy_o, pc_set_o;
  ctrl_pkg::pc_mux_t     pc_mux_o;
  ctrl_pkg::exc_pc_mux_t exc_pc_mux_o;
  ctrl_pkg::exc_cause_t  exc_vec_sel_o, irq_id_o;
  logic                  kill_if_o, kill_id_o, kill_ex_o, kill_wb_o;
  logic                  halt_if_o, halt_id_o, halt_ex_o, halt_wb_o;
  logic                  irq_ack_o, csr_save_cause_o;
  ctrl_pkg::csr_cause_t  csr_cause_o;
  ctrl_pkg::save_sel_t   csr_save_sel_o;

  // Vector mode as last written through the config port
  ctrl_pkg::vec_mode_t   vec_mode_model = ctrl_pkg::VEC_MODE_DIRECT;
  logic [31:0]           lcg_state = 32'd70;
  int                    row_idx = 0;
  int                    cycles = 0;

  pipe_ctrl_top pipe_ctrl_top_inst (.*);

  always #HALF_PERIOD clk = ~clk;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int total_hold();
    row_t r;
    int   sum;
    sum = 0;
    for (int i = 0; i < NUM_ROWS; i++) begin
      r = table_row(i);
      sum += int'(r.hold);
    end
    return sum;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Mismatch at %0t row %0d: %s got %0h expected %0h", $time, row_idx, name, got, exp);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_pc(input string name, input ctrl_pkg::pc_mux_t got,
                          input ctrl_pkg::pc_mux_t exp);
    if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
  endtask

  task automatic check_cause(input string name, input ctrl_pkg::csr_cause_t got,
                             input ctrl_pkg::csr_cause_t exp);
    if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
  endtask

  task automatic check_code(input string name, input ctrl_pkg::exc_cause_t got,
                            input ctrl_pkg::exc_cause_t exp);
    if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
  endtask

  task automatic check_sel(input string name, input ctrl_pkg::save_sel_t got,
                           input ctrl_pkg::save_sel_t exp);
    if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
  endtask

  task automatic check_base(input string name, input ctrl_pkg::exc_pc_mux_t got,
                            input ctrl_pkg::exc_pc_mux_t exp);
    if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
  endtask

  //////////////////////////////////////////////////
  // Drive and check one cycle
  //////////////////////////////////////////////////

  task automatic drive_row(input row_t r);
    lcg_state = lcg_next(lcg_state);
    {cfg_we_i, cfg_sel_i, cfg_wdata_i} = r.cfg;
    fetch_enable_i = r.fe;
    {if_fire_i, id_valid_i, id_jump_i, jr_stall_i, load_stall_i} = r.ifid;
    {ex_valid_i, ex_branch_i, ex_lsu_misaligned_i, ex_stall_i, ex_advance_i, data_req_i} = r.ex;
    {wb_valid_i, wb_instr_fault_i, wb_illegal_i, wb_ecall_i, wb_ebreak_i,
     wb_load_fault_i, wb_store_fault_i, wb_lsu_en_i, wb_wfi_i} = r.wb;
    {irq_req_i, irq_wu_i} = r.irq;
    // Upper LCG bits, the low ones repeat quickly
    irq_id_i = lcg_state[20:16];
    // Flags that a higher priority event overrules
    if (r.dc[1]) id_jump_i = lcg_state[24];
    if (r.dc[0]) ex_branch_i = lcg_state[27];
  endtask

  task automatic check_row(input row_t r);
    ctrl_pkg::exc_cause_t exp_vec;
    exp_vec = (vec_mode_model == ctrl_pkg::VEC_MODE_DIRECT) ? 5'd0 : irq_id_i;
    check_bit("instr_req_o", instr_req_o, r.e_rb[1]);
    check_bit("ctrl_busy_o", ctrl_busy_o, r.e_rb[0]);
    check_bit("pc_set_o", pc_set_o, r.e_set);
    if (r.e_set) check_pc("pc_mux_o", pc_mux_o, r.e_mux);
    check_bit("kill_if_o", kill_if_o, r.e_kill[3]);
    check_bit("kill_id_o", kill_id_o, r.e_kill[2]);
    check_bit("kill_ex_o", kill_ex_o, r.e_kill[1]);
    check_bit("kill_wb_o", kill_wb_o, r.e_kill[0]);
    check_bit("halt_if_o", halt_if_o, r.e_halt[3]);
    check_bit("halt_id_o", halt_id_o, r.e_halt[2]);
    check_bit("halt_ex_o", halt_ex_o, r.e_halt[1]);
    check_bit("halt_wb_o", halt_wb_o, r.e_halt[0]);
    check_bit("irq_ack_o", irq_ack_o, r.e_as[1]);
    check_bit("csr_save_cause_o", csr_save_cause_o, r.e_as[0]);
    if (r.e_as[1]) begin
      // Interrupt cause carries the id with the top bit set
      check_cause("csr_cause_o", csr_cause_o, {1'b1, irq_id_i});
      check_code("irq_id_o", irq_id_o, irq_id_i);
      check_code("exc_vec_sel_o", exc_vec_sel_o, exp_vec);
      check_base("exc_pc_mux_o", exc_pc_mux_o, ctrl_pkg::EXC_PC_IRQ);
    end else if (r.e_as[0]) begin
      check_cause("csr_cause_o", csr_cause_o, {1'b0, r.e_exc});
      check_base("exc_pc_mux_o", exc_pc_mux_o, ctrl_pkg::EXC_PC_EXCEPTION);
    end
    if (r.e_as[0]) check_sel("csr_save_sel_o", csr_save_sel_o, r.e_sel);
  endtask

  //////////////////////////////////////////////////
  // Main sequence and timeout
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= 4 * total_hold() + 50) begin
      $display("Timeout after %0d cycles, table not finished", cycles);
      $display("CHECKS FAILED");
      $fatal(1);
    end
  end

  initial begin
    row_t r;
    r = '0;
    rst_n = 1'b0;
    drive_row(r);
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < NUM_ROWS; i++) begin
      r = table_row(i);
      row_idx = i;
      for (int k = 0; k < int'(r.hold); k++) begin
        @(negedge clk);
        drive_row(r);
        // Mid low phase, outputs settled
        #(HALF_PERIOD / 2);
        check_row(r);
      end
      if (r.cfg[3] && (r.cfg[2] == ctrl_pkg::CFG_SEL_VEC_MODE)) begin
        vec_mode_model = r.cfg[1:0];
      end
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* list.f */
+incdir+test
verilog/ctrl_pkg.sv
verilog/ctrl_cfg_regs.sv
verilog/ctrl_event_decode.sv
verilog/ctrl_fsm.sv
verilog/pipe_ctrl_top.sv
test/tb_pipe_ctrl.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        = tb_pipe_ctrl
RTL_TOP    = pipe_ctrl_top
FILELIST   = list.f
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert -j 0
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_TEXT  = ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
